/* vlog.f */
design/rom_load_pkg.sv
design/rom_region_map.sv
design/rom_cfg_regs.sv
design/rom_prog_writer.sv
design/rom_loader_top.sv
testbench/tb_rom_loader.sv

/* Makefile */
# Verilator build of the ROM loader testbench

TOP = tb_rom_loader
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module rom_loader_top
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** TEST FAILED ***' $(LOG); then \
	    echo "simulation failed, see $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_rom_loader.sv */
// sdram is only an ack model with 0-5 cycle latency; host waits for each ack before the next byte
`timescale 1ns/100ps

module tb_rom_loader import rom_load_pkg::*; ();

    logic                clk;
    logic                reset;
    logic                downloading;
    logic [ioctl_aw-1:0] ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    logic                sdram_ack;
    logic [cfg_iw-1:0]   cfg_rd_index;
    logic [prog_aw-1:0]  prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;
    logic [1:0]          prog_bank;
    logic                prog_we;
    logic [7:0]          cfg_rd_data;

    int          errors;
    int          checks;
    int unsigned snd_units;           // region starts in kB as sent
    int unsigned oki_units;
    int unsigned gfx_units;
    logic        crypt_on;            // byte 39 bit 7 seen in this download
    logic        ack_hold;            // stalls the sdram model
    logic [7:0]  cfg_ref [cfg_count]; // expected config bytes

    rom_loader_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .sdram_ack    (sdram_ack),
        .cfg_rd_index (cfg_rd_index),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_mask    (prog_mask),
        .prog_bank    (prog_bank),
        .prog_we      (prog_we),
        .cfg_rd_data  (cfg_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 50 MHz
    end

    // sdram model acks a pending write after 0-5 cycles
    initial begin
        int delay;
        int held;
        sdram_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (prog_we) begin
                delay = $urandom_range(5, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                held = 0;
                while (ack_hold && held < 200) begin  // back-pressure from the test
                    @(posedge clk);
                    #2;
                    held++;
                end
                if (ack_hold) begin
                    $display("Timeout: sdram model was held for 200 cycles");
                    errors++;
                end
                sdram_ack = 1'b1;   // one cycle ack
                @(posedge clk);
                #2;
                sdram_ack = 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // reference decoder table where bits 3 and 7 count when clear
    function automatic logic [7:0] ref_decrypt(input logic [7:0] d);
        logic [7:0] term [8];
        logic [7:0] r;
        logic       active;
        term = '{8'h04, 8'h21, 8'h01, 8'h50, 8'h40, 8'h06, 8'h08, 8'h88};
        r    = 8'h00;
        for (int b = 0; b < 8; b++) begin
            active = (b == 3 || b == 7) ? !d[b] : d[b];
            if (active)
                r = r ^ term[b];
        end
        return r;
    endfunction

    // one strobe that returns just after the edge registering it
    task automatic send_byte(input int unsigned addr, input logic [7:0] data);
        ioctl_addr = ioctl_aw'(addr);
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr   = 1'b0;
    endtask

    task automatic start_download();
        downloading = 1'b1;
        crypt_on    = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic end_download();
        downloading = 1'b0;
        crypt_on    = 1'b0;
        @(posedge clk);
        #2;
        check_value("prog_we", 32'(prog_we), 32'd0);
        check_value("decrypt", 32'(i_dut.i_cfg.decrypt), 32'd0);
    endtask

    // header bytes 6 and up never request a write
    task automatic send_header_byte(input int unsigned index, input logic [7:0] data);
        send_byte(index, data);
        check_value("prog_we", 32'(prog_we), 32'd0);
        if (index >= cfg_first && index <= cfg_last)
            cfg_ref[index - cfg_first] = data;
        if (index == cfg_byte)
            crypt_on = data[cfg_decrypt_bit];
    endtask

    task automatic send_starts(input int unsigned snd, input int unsigned oki,
                               input int unsigned gfx);
        logic [47:0] hdr;
        hdr = {16'(gfx), 16'(oki), 16'(snd)};   // little-endian words
        for (int i = 0; i < start_bytes; i++) begin
            send_byte(i, hdr[8*i +: 8]);
            check_value("prog_we", 32'(prog_we), 32'd0);
        end
        snd_units = snd;
        oki_units = oki;
        gfx_units = gfx;
    endtask

    task automatic check_write(input logic [prog_aw-1:0] addr, input logic [7:0] data,
                               input logic [1:0] mask, input logic [1:0] bank);
        check_value("prog_we", 32'(prog_we), 32'd1);
        check_value("prog_addr", 32'(prog_addr), 32'(addr));
        check_value("prog_data", 32'(prog_data), 32'(data));
        check_value("prog_mask", 32'(prog_mask), 32'(mask));
        check_value("prog_bank", 32'(prog_bank), 32'(bank));
    endtask

    // write must stay put until the ack and prog_we drops after it
    task automatic wait_for_ack(input logic [prog_aw-1:0] addr, input logic [7:0] data,
                                input logic [1:0] mask, input logic [1:0] bank);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!sdram_ack && cycles < 40) begin
            check_write(addr, data, mask, bank);
            @(negedge clk);
            cycles++;
        end
        if (sdram_ack) begin
            check_write(addr, data, mask, bank);
        end else begin
            $display("Timeout: no sdram ack for the write to %h", addr);
            errors++;
        end
        @(posedge clk);
        #2;
        check_value("prog_we", 32'(prog_we), 32'd0);
    endtask

    // body byte where hold keeps the ack back for 8 cycles
    task automatic write_body(input int unsigned body, input logic [7:0] data,
                              input logic hold);
        int unsigned        units;
        int unsigned        base;
        logic [prog_aw-1:0] offset;
        logic [prog_aw-1:0] exp_addr;
        logic [7:0]         exp_data;
        logic [1:0]         exp_mask;
        logic [1:0]         exp_bank;
        logic               is_cpu;
        units  = body >> 10;    // kB units
        is_cpu = 1'b0;
        if (units < snd_units) begin
            base     = 0;
            offset   = cpu_offset;
            exp_bank = bank_cpu;
            is_cpu   = 1'b1;
        end else if (units < oki_units) begin
            base     = snd_units;
            offset   = snd_offset;
            exp_bank = bank_other;
        end else if (units < gfx_units) begin
            base     = oki_units;
            offset   = oki_offset;
            exp_bank = bank_other;
        end else begin
            base     = gfx_units;
            offset   = gfx_offset;
            exp_bank = bank_gfx;
        end
        exp_addr = prog_aw'((body - base * 1024) / 2) + offset;
        exp_mask = body[0] ? 2'b01 : 2'b10;      // active low lanes
        exp_data = (is_cpu && crypt_on && body[19] && !body[0]) ? ref_decrypt(data) : data;
        if (hold)
            ack_hold = 1'b1;
        send_byte(body + full_header, data);
        check_write(exp_addr, exp_data, exp_mask, exp_bank);
        if (hold) begin
            repeat (8) begin
                @(negedge clk);
                check_write(exp_addr, exp_data, exp_mask, exp_bank);
            end
            ack_hold = 1'b0;
        end
        wait_for_ack(exp_addr, exp_data, exp_mask, exp_bank);
    endtask

    // lets the model finish an ack for a write that was already dropped
    task automatic drain_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!sdram_ack && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!sdram_ack) begin
            $display("Timeout: sdram model never released the held write");
            errors++;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic load_header_regions();
        start_download();
        send_starts(2, 4, 8);
        write_body(32'h000123, 8'ha5, 1'b0);   // odd cpu byte
        write_body(32'h000400, 8'h17, 1'b0);   // even cpu byte
        write_body(32'h000900, 8'h3c, 1'b0);   // snd
        write_body(32'h000c01, 8'h81, 1'b0);
        write_body(32'h001402, 8'h96, 1'b0);   // oki
        write_body(32'h002100, 8'h0f, 1'b0);   // gfx
        write_body(32'h00f3ff, 8'($urandom_range(255, 0)), 1'b0);
        end_download();
    endtask

    task automatic write_config_bytes();
        start_download();
        for (int a = start_bytes; a < full_header; a++) begin
            send_header_byte(a, 8'($urandom_range(255, 0)));
        end
        end_download();
        // bytes persist past the download
        for (int i = 0; i < cfg_count; i++) begin
            cfg_rd_index = cfg_iw'(i);
            @(negedge clk);
            check_value($sformatf("cfg_rd_data[%0d]", i), 32'(cfg_rd_data), 32'(cfg_ref[i]));
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_decryption();
        start_download();
        send_starts(32'h400, 32'h800, 32'hc00);   // 1 MB of cpu code
        send_header_byte(cfg_byte, 8'h80);
        write_body(32'h080010, 8'h3c, 1'b0);    // even byte in the upper half
        for (int k = 0; k < 4; k++) begin
            write_body(32'h080020 + 2 * k, 8'($urandom_range(255, 0)), 1'b0);
        end
        write_body(32'h080011, 8'h3c, 1'b0);    // odd lane
        write_body(32'h000010, 8'h3c, 1'b0);    // bit 19 low
        write_body(32'h180010, 8'h3c, 1'b0);    // snd
        write_body(32'h380020, 8'h3c, 1'b0);    // gfx
        send_header_byte(cfg_byte, 8'h7f);      // switch it off again
        write_body(32'h080010, 8'h3c, 1'b0);
        write_body(32'h0a0012, 8'($urandom_range(255, 0)), 1'b0);
        end_download();
    endtask

    task automatic hold_until_ack();
        start_download();
        send_starts(2, 4, 8);
        write_body(32'h000902, 8'h5a, 1'b1);
        write_body(32'h002205, 8'hc3, 1'b1);
        write_body(32'h000042, 8'h99, 1'b0);
        end_download();
    endtask

    task automatic end_download_clears();
        start_download();
        send_starts(32'h400, 32'h800, 32'hc00);
        send_header_byte(cfg_byte, 8'h80);
        check_value("decrypt", 32'(i_dut.i_cfg.decrypt), 32'd1);
        ack_hold = 1'b1;
        send_byte(32'h080010 + full_header, 8'h3c);
        check_value("prog_we", 32'(prog_we), 32'd1);
        end_download();       // pending write and crypt flag both gone
        @(negedge clk);
        ack_hold = 1'b0;
        drain_ack();
        // fresh image without byte 39
        start_download();
        send_starts(32'h400, 32'h800, 32'hc00);
        write_body(32'h080010, 8'h3c, 1'b0);
        write_body(32'h080ff4, 8'he1, 1'b0);
        end_download();
    endtask

    initial begin
        void'($urandom(35));
        errors       = 0;
        checks       = 0;
        reset        = 1'b1;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = 8'h00;
        ioctl_wr     = 1'b0;
        cfg_rd_index = '0;
        ack_hold     = 1'b0;
        crypt_on     = 1'b0;
        snd_units    = 0;
        oki_units    = 0;
        gfx_units    = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        check_value("prog_we", 32'(prog_we), 32'd0);

        load_header_regions();
        write_config_bytes();
        check_decryption();
        hold_until_ack();
        end_download_clears();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* design/rom_loader_top.sv */
// sdram controller is external; host must pace strobes to the sdram acks
`timescale 1ns/100ps

module rom_loader_top import rom_load_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    input  logic [cfg_iw-1:0]   cfg_rd_index,
    output logic [prog_aw-1:0]  prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_bank,
    output logic                prog_we,
    output logic [7:0]          cfg_rd_data
);

    logic [1:0]         kind;       // start / cfg / body / reserved
    logic [1:0]         region;
    logic [prog_aw-1:0] rel_addr;   // word address inside the region
    logic               cfg_wr;
    logic [cfg_iw-1:0]  cfg_index;
    logic               decrypt;

    // address decode and start header
    rom_region_map i_map (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .kind        (kind),
        .region      (region),
        .rel_addr    (rel_addr),
        .cfg_wr      (cfg_wr),
        .cfg_index   (cfg_index)
    );

    // game config bytes
    rom_cfg_regs i_cfg (
        .clk          (clk),
        .reset        (reset),
        .downloading  (downloading),
        .cfg_wr       (cfg_wr),
        .cfg_index    (cfg_index),
        .ioctl_data   (ioctl_data),
        .cfg_rd_index (cfg_rd_index),
        .cfg_rd_data  (cfg_rd_data),
        .decrypt      (decrypt)
    );

    // sdram programming port
    rom_prog_writer i_writer (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .kind        (kind),
        .region      (region),
        .rel_addr    (rel_addr),
        .decrypt     (decrypt),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_bank   (prog_bank),
        .prog_we     (prog_we)
    );

endmodule

/* design/rom_prog_writer.sv */
// one write in flight; a new body strobe before the ack replaces the pending write
`timescale 1ns/100ps

module rom_prog_writer import rom_load_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic                ioctl_wr,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic [1:0]          kind,
    input  logic [1:0]          region,
    input  logic [prog_aw-1:0]  rel_addr,
    input  logic                decrypt,
    input  logic                sdram_ack,
    output logic [prog_aw-1:0]  prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,   // active low
    output logic [1:0]          prog_bank,
    output logic                prog_we
);

    logic [prog_aw-1:0] region_offset;
    logic [1:0]         region_bank;
    logic               crypt_sel;      // this byte goes through the decoder
    logic [7:0]         data_next;
    logic [1:0]         mask_next;
    logic               body_wr;

    assign body_wr = ioctl_wr && downloading && kind == kind_body;

    // per region sdram placement
    always_comb begin
        case (region)
            region_cpu: begin
                region_offset = cpu_offset;
                region_bank   = bank_cpu;
            end
            region_snd: begin
                region_offset = snd_offset;
                region_bank   = bank_other;
            end
            region_oki: begin
                region_offset = oki_offset;
                region_bank   = bank_other;
            end
            default: begin
                region_offset = gfx_offset;
                region_bank   = bank_gfx;
            end
        endcase
    end

    // cpu rel_addr is the body word address, so byte bit 19 is word bit 18
    // only even bytes of the upper half are scrambled
    assign crypt_sel = region == region_cpu && decrypt &&
                       rel_addr[crypt_addr_bit-1] && !ioctl_addr[0];

    assign data_next = crypt_sel ? decrypt_byte(ioctl_data) : ioctl_data;
    assign mask_next = ioctl_addr[0] ? 2'b01 : 2'b10;    // odd byte -> upper lane

    // write payload, held while prog_we waits for the ack
    always_ff @(posedge clk) begin
        if (body_wr) begin
            prog_addr <= rel_addr + region_offset;
            prog_data <= data_next;
            prog_mask <= mask_next;
            prog_bank <= region_bank;
        end
    end

    // write request level
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (ioctl_wr && downloading) begin
            prog_we <= kind == kind_body;   // header bytes never request
        end else if (!downloading || sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

endmodule

/* design/rom_cfg_regs.sv */
// config bytes persist across downloads until reset; decrypt flag only lives during one download
`timescale 1ns/100ps

module rom_cfg_regs import rom_load_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              downloading,
    input  logic              cfg_wr,
    input  logic [cfg_iw-1:0] cfg_index,
    input  logic [7:0]        ioctl_data,
    input  logic [cfg_iw-1:0] cfg_rd_index,
    output logic [7:0]        cfg_rd_data,
    output logic              decrypt
);

    logic [7:0] regs [cfg_count];   // header bytes 8 to 39
    logic       decrypt_hit;        // current write targets the crypt byte

    assign decrypt_hit = cfg_wr && cfg_index == cfg_iw'(cfg_byte - cfg_first);

    // register file, one byte per strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cfg_count; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (cfg_wr) begin
            regs[cfg_index] <= ioctl_data;
        end
    end

    // decrypt enable
    always_ff @(posedge clk) begin
        if (reset) begin
            decrypt <= 1'b0;
        end else if (!downloading) begin
            decrypt <= 1'b0;        // next image must ask again
        end else if (decrypt_hit) begin
            decrypt <= ioctl_data[cfg_decrypt_bit];
        end
    end

    // read back, no latency
    assign cfg_rd_data = regs[cfg_rd_index];

endmodule

/* design/rom_region_map.sv */
// region starts must be ascending and are only valid once all six start bytes arrived
`timescale 1ns/100ps

module rom_region_map import rom_load_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                downloading,
    input  logic                ioctl_wr,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_data,
    output logic [1:0]          kind,
    output logic [1:0]          region,
    output logic [prog_aw-1:0]  rel_addr,
    output logic                cfg_wr,
    output logic [cfg_iw-1:0]   cfg_index
);

    logic [8*start_bytes-1:0]             starts;     // little-endian, byte 0 lowest
    logic [15:0]                          snd_start;
    logic [15:0]                          oki_start;
    logic [15:0]                          gfx_start;
    logic [ioctl_aw-1:0]                  bulk_addr;  // address with header removed
    logic [ioctl_aw-start_unit_bits-1:0]  bulk_unit;  // same, in kB
    logic [15:0]                          base_unit;
    logic [ioctl_aw-1:0]                  region_base;
    logic [ioctl_aw-1:0]                  rel_byte;
    logic [ioctl_aw-1:0]                  cfg_byte_addr;

    assign snd_start = starts[15:0];
    assign oki_start = starts[31:16];
    assign gfx_start = starts[47:32];

    // header kind straight from the byte address
    always_comb begin
        if (ioctl_addr < ioctl_aw'(start_bytes))
            kind = kind_start;
        else if (ioctl_addr >= ioctl_aw'(cfg_first) && ioctl_addr <= ioctl_aw'(cfg_last))
            kind = kind_cfg;
        else if (ioctl_addr >= ioctl_aw'(full_header))
            kind = kind_body;
        else
            kind = kind_rsvd;  // bytes 6-7 and 40-63
    end

    // start bytes shift in from the top
    always_ff @(posedge clk) begin
        if (reset) begin
            starts <= '0;
        end else if (ioctl_wr && downloading && kind == kind_start) begin
            starts <= {ioctl_data, starts[8*start_bytes-1:8]};
        end
    end

    assign bulk_addr = ioctl_addr - ioctl_aw'(full_header);
    assign bulk_unit = bulk_addr[ioctl_aw-1:start_unit_bits];

    // region lookup, first start that is still ahead wins
    always_comb begin
        if ({1'b0, bulk_unit} < snd_start) begin
            region    = region_cpu;
            base_unit = 16'd0;          // cpu code sits at body start
        end else if ({1'b0, bulk_unit} < oki_start) begin
            region    = region_snd;
            base_unit = snd_start;
        end else if ({1'b0, bulk_unit} < gfx_start) begin
            region    = region_oki;
            base_unit = oki_start;
        end else begin
            region    = region_gfx;
            base_unit = gfx_start;
        end
    end

    // kB units back to bytes, top bit dropped at 32 MB
    assign region_base = ioctl_aw'({base_unit, {start_unit_bits{1'b0}}});
    assign rel_byte    = bulk_addr - region_base;
    assign rel_addr    = rel_byte[prog_aw:1];  // 16-bit words

    // config window
    assign cfg_byte_addr = ioctl_addr - ioctl_aw'(cfg_first);
    assign cfg_index     = cfg_byte_addr[cfg_iw-1:0];
    assign cfg_wr        = ioctl_wr && downloading && kind == kind_cfg;

endmodule

/* design/rom_load_pkg.sv */
// image at most 32 MB; offsets and region codes are shared with the testbench
package rom_load_pkg;

    // address widths
    localparam int ioctl_aw = 25;              // byte address from the host, 32 MB max
    localparam int prog_aw  = 22;              // sdram word address

    // header layout
    localparam int start_bytes     = 6;        // three 16-bit region starts
    localparam int cfg_first       = 8;        // first game config byte
    localparam int cfg_last        = 39;       // last game config byte
    localparam int cfg_count       = cfg_last - cfg_first + 1;
    localparam int cfg_iw          = $clog2(cfg_count);
    localparam int cfg_byte        = 39;       // holds the decryption enable
    localparam int cfg_decrypt_bit = 7;
    localparam int full_header     = 64;       // skipped before the body starts
    localparam int start_unit_bits = 10;       // starts counted in 1 kB units
    localparam int crypt_addr_bit  = 19;       // body address bit that selects encrypted code

    // region codes
    localparam logic [1:0] region_cpu = 2'd0;
    localparam logic [1:0] region_snd = 2'd1;
    localparam logic [1:0] region_oki = 2'd2;
    localparam logic [1:0] region_gfx = 2'd3;

    // what kind of byte the host is sending
    localparam logic [1:0] kind_start = 2'd0;  // region start bytes
    localparam logic [1:0] kind_cfg   = 2'd1;  // config registers
    localparam logic [1:0] kind_body  = 2'd2;  // rom data
    localparam logic [1:0] kind_rsvd  = 2'd3;  // unused header bytes, dropped

    // sdram word offsets per region
    localparam logic [prog_aw-1:0] cpu_offset = 22'h004000;
    localparam logic [prog_aw-1:0] snd_offset = 22'h000000;
    localparam logic [prog_aw-1:0] oki_offset = 22'h010000;
    localparam logic [prog_aw-1:0] gfx_offset = 22'h020000;

    // sdram banks
    localparam logic [1:0] bank_cpu   = 2'b01;
    localparam logic [1:0] bank_gfx   = 2'b10;
    localparam logic [1:0] bank_other = 2'b00;

    // cpu code scrambling, one xor term per input bit
    function automatic logic [7:0] decrypt_byte(input logic [7:0] d);
        logic [7:0] r;
        r = 8'h00;
        if (d[0])  r = r ^ 8'h04;
        if (d[1])  r = r ^ 8'h21;
        if (d[2])  r = r ^ 8'h01;
        if (!d[3]) r = r ^ 8'h50;   // inverted sense
        if (d[4])  r = r ^ 8'h40;
        if (d[5])  r = r ^ 8'h06;
        if (d[6])  r = r ^ 8'h08;
        if (!d[7]) r = r ^ 8'h88;   // inverted sense
        return r;
    endfunction

endpackage
